/* sources.f */
source/rx_frame_pkg.sv
source/rx_buff_pkg.sv
source/rx_bank_if.sv
source/rx_buff_bank.sv
source/rx_buff_writer.sv
source/rx_buff_reader.sv
source/rx_buff.sv
verification/rx_buff_checker.sv
verification/rx_buff_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rx_buff testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rx_buff_tb -f sources.f -o rx_buff_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

./obj_dir/rx_buff_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* verification/rx_buff_tb.sv */
`timescale 1ns/1ns

module rx_buff_tb
	import rx_frame_pkg::*;
;

	localparam int WORD_W     = 64;
	localparam int DATA_WORDS = 8;
	localparam int FRM_W      = WORD_W * DATA_WORDS;
	localparam int EXP_W      = (DATA_WORDS + 1) * WORD_W;
	localparam int N_TESTS    = 6;
	localparam int N_RAND     = 12;
	// each random round can hold up to three frames of work.
	localparam int WD_NS      = (N_TESTS + 3 * N_RAND) * (DATA_WORDS + 20) * 20 * 2;

	logic              clk;
	logic              g_rst;
	logic              acpt_sts;
	logic              rd_en;
	logic [ID_W-1:0]   prio_id;
	logic [DLC_W-1:0]  dlc;
	logic              rrs;
	logic              ide;
	logic              fdf;
	logic              xlf;
	logic              resxl;
	logic [SDT_W-1:0]  sdt;
	logic [VCID_W-1:0] vcid;
	logic              sec;
	logic [FRM_W-1:0]  data_frm;
	logic [WORD_W-1:0] data_out;
	logic              buff_rdy;
	logic              wrtn0;
	logic              wrtn1;
	logic [EXP_W-1:0]  exp_words;
	logic [31:0]       seed;
	logic              test_end;
	int                test_id;
	int                tb_errs;
	int                err_cnt;
	int                frames_done;
	int                aborts;
	int                pending;
	logic              in_frame;

	rx_buff #(.WORD_W(WORD_W), .DATA_WORDS(DATA_WORDS)) dut (
		.clk            (clk),
		.g_rst          (g_rst),
		.acpt_sts       (acpt_sts),
		.rd_en          (rd_en),
		.rcvd_prio_id   (prio_id),
		.rcvd_dlc       (dlc),
		.rcvd_rrs       (rrs),
		.ide            (ide),
		.fdf            (fdf),
		.xlf            (xlf),
		.resxl          (resxl),
		.sdt            (sdt),
		.vcid           (vcid),
		.sec            (sec),
		.rcvd_data_frm  (data_frm),
		.data_out       (data_out),
		.buff_rdy       (buff_rdy),
		.rx_buff_0_wrtn (wrtn0),
		.rx_buff_1_wrtn (wrtn1)
	);

	rx_buff_checker #(.WORD_W(WORD_W), .DATA_WORDS(DATA_WORDS)) chk (
		.clk         (clk),
		.g_rst       (g_rst),
		.acpt_sts    (acpt_sts),
		.rd_en       (rd_en),
		.exp_words   (exp_words),
		.data_out    (data_out),
		.buff_rdy    (buff_rdy),
		.wrtn0       (wrtn0),
		.wrtn1       (wrtn1),
		.test_id     (test_id),
		.test_end    (test_end),
		.extra_errs  (tb_errs),
		.err_cnt     (err_cnt),
		.frames_done (frames_done),
		.aborts      (aborts),
		.pending     (pending),
		.in_frame    (in_frame)
	);

	// header word on top, then the frame slices from the top down.
	function automatic logic [EXP_W-1:0] expected_frame(
		input logic [ID_W-1:0]   f_id,
		input logic              f_rrs,
		input logic              f_ide,
		input logic              f_fdf,
		input logic              f_xlf,
		input logic              f_resxl,
		input logic [SDT_W-1:0]  f_sdt,
		input logic              f_sec,
		input logic [DLC_W-1:0]  f_dlc,
		input logic [VCID_W-1:0] f_vcid,
		input logic [FRM_W-1:0]  f_data
	);
		logic [DLC_W-1:0]  d;
		logic [HDR_W-1:0]  h;
		logic [WORD_W-1:0] hw;
		d  = f_sec ? f_dlc - DLC_W'(16) : f_dlc;	// wraps mod 2048.
		h  = {f_id, f_rrs, f_ide, f_fdf, f_xlf, f_resxl, f_sdt, f_sec, d, f_vcid};
		hw = '0;
		hw[WORD_W-1 -: HDR_W] = h;
		return {hw, f_data};
	endfunction

	assign exp_words = expected_frame(prio_id, rrs, ide, fdf, xlf, resxl, sdt, sec, dlc,
		vcid, data_frm);

	function automatic logic [31:0] xorshift32();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	task automatic new_frame(input logic s);
		logic [31:0] r;
		r       = xorshift32();
		prio_id = r[ID_W-1:0];
		if (prio_id == '0)
			prio_id = ID_W'(1);	// keeps the header word nonzero.
		rrs   = r[11];
		ide   = r[12];
		fdf   = r[13];
		xlf   = r[14];
		resxl = r[15];
		sdt   = r[23:16];
		vcid  = r[31:24];
		r     = xorshift32();
		dlc   = r[DLC_W-1:0];
		sec   = s;
		data_frm = '0;
		repeat ((FRM_W + 31) / 32)
			data_frm = (data_frm << 32) | FRM_W'(xorshift32());
	endtask

	task automatic accept_frame();
		acpt_sts = 1'b1;
		@(negedge clk);
		acpt_sts = 1'b0;
	endtask

	task automatic read_frames(input int count);
		int target;
		@(posedge clk);
		target = frames_done + count;
		@(negedge clk);
		rd_en = 1'b0;
		do
			@(posedge clk);
		while (frames_done < target);
		@(negedge clk);
		rd_en = 1'b1;
		repeat (5) @(negedge clk);
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		tb_errs++;
	endtask

	task automatic expect_empty();
		@(negedge clk);
		if (wrtn0 || wrtn1)
			note_failure("a bank is still written after its readout");
	endtask

	task automatic close_test();
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
		test_id++;
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	initial
	begin
		#(WD_NS);
		$display("timeout: the tests did not finish within %0d ns", WD_NS);
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		int          base;
		int          n;
		int          len;
		logic [31:0] r;
		g_rst    = 1'b1;
		acpt_sts = 1'b0;
		rd_en    = 1'b1;	// active low.
		prio_id  = '0;
		dlc      = '0;
		rrs      = 1'b0;
		ide      = 1'b0;
		fdf      = 1'b0;
		xlf      = 1'b0;
		resxl    = 1'b0;
		sdt      = '0;
		vcid     = '0;
		sec      = 1'b0;
		data_frm = '0;
		seed     = 32'hd54d_d1ad;
		test_id  = 1;
		test_end = 1'b0;
		tb_errs  = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		g_rst = 1'b0;
		@(negedge clk);
		close_test();

		new_frame(1'b0);
		accept_frame();
		repeat (2) @(negedge clk);	// buff_rdy trails the flag.
		read_frames(1);
		expect_empty();
		close_test();

		new_frame(1'b1);
		dlc = DLC_W'(5);	// wraps below zero.
		accept_frame();
		read_frames(1);
		expect_empty();
		close_test();

		g_rst = 1'b1;	// bank 0 reads first again.
		repeat (4) @(negedge clk);
		g_rst = 1'b0;
		@(negedge clk);
		repeat (3)
		begin
			new_frame(1'b0);
			accept_frame();
		end
		read_frames(2);
		expect_empty();
		close_test();

		new_frame(1'b0);
		accept_frame();
		@(posedge clk);
		base = aborts;
		@(negedge clk);
		rd_en = 1'b0;
		do
			@(posedge clk);
		while (!in_frame);
		repeat (3) @(negedge clk);
		rd_en = 1'b1;
		repeat (7) @(negedge clk);
		if (aborts == base)
			note_failure("raising rd_en mid frame did not abort the readout");
		if (!wrtn0)
			note_failure("bank not kept written after the abort");
		read_frames(1);
		expect_empty();
		close_test();

		for (int i = 0; i < N_RAND; i++)
		begin
			r = xorshift32();
			n = int'(r % 32'd4);
			for (int j = 0; j < n; j++)
			begin
				r = xorshift32();
				new_frame(r[0]);
				accept_frame();
			end
			r   = xorshift32();
			len = 3 + int'(r % 32'(2 * DATA_WORDS + 10));
			rd_en = 1'b0;
			repeat (len) @(negedge clk);
			rd_en = 1'b1;
			repeat (5) @(negedge clk);
		end
		rd_en = 1'b0;	// drain what is left.
		do
			@(posedge clk);
		while (pending != 0 || in_frame);
		@(negedge clk);
		rd_en = 1'b1;
		repeat (5) @(negedge clk);
		close_test();

		$display("tests %0d, frames %0d, aborts %0d, errors %0d", N_TESTS, frames_done,
			aborts, err_cnt + tb_errs);
		if (err_cnt + tb_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* verification/rx_buff_checker.sv */
`timescale 1ns/1ns

module rx_buff_checker
	import rx_buff_pkg::*;
#(
	parameter int WORD_W     = 64,
	parameter int DATA_WORDS = 8
) (
	input  logic                             clk,
	input  logic                             g_rst,
	input  logic                             acpt_sts,
	input  logic                             rd_en,
	input  logic [(DATA_WORDS+1)*WORD_W-1:0] exp_words,
	input  logic [WORD_W-1:0]                data_out,
	input  logic                             buff_rdy,
	input  logic                             wrtn0,
	input  logic                             wrtn1,
	input  int                               test_id,
	input  logic                             test_end,
	input  int                               extra_errs,
	output int                               err_cnt,
	output int                               frames_done,
	output int                               aborts,
	output int                               pending,
	output logic                             in_frame
);

	logic [WORD_W-1:0] bank_mem [0:1][0:DATA_WORDS];	// expected bank contents.
	logic [1:0]        model_w;
	logic              rdy_m;
	logic              lat_arm;
	logic              rd_prev;
	bank_sel_t         cur;
	bank_sel_t         last;
	int                idx;
	int                lat_cnt;
	int                errs_base;

	function automatic string test_name(input int id);
		case (id)
			1: return "reset";
			2: return "single_frame";
			3: return "secured_dlc";
			4: return "both_banks_drop";
			5: return "read_abort";
			6: return "random_frames";
			default: return "unknown";
		endcase
	endfunction

	task automatic report_word(input string what, input logic [WORD_W-1:0] exp_v,
			input logic [WORD_W-1:0] act_v);
		$display("ERR %s: %s expected %h actual %h", test_name(test_id), what, exp_v, act_v);
		err_cnt++;
	endtask

	task automatic report_text(input string msg);
		$display("%s: %s", test_name(test_id), msg);
		err_cnt++;
	endtask

	task automatic store_frame(input int b);
		for (int k = 0; k <= DATA_WORDS; k++)
			bank_mem[b][k] = exp_words[(DATA_WORDS - k) * WORD_W +: WORD_W];
		model_w[b] = 1'b1;
	endtask

	task automatic follow_stream();
		logic [WORD_W-1:0] exp_v;
		if (!in_frame && data_out != '0)
		begin
			if (model_w == 2'b00)
				report_text("data_out active while no bank is written");
			else
			begin
				if (model_w == 2'b11)
					cur = (last == BANK_0) ? BANK_1 : BANK_0;	// alternate.
				else if (model_w[1])
					cur = BANK_1;
				else
					cur = BANK_0;
				if (lat_arm && lat_cnt != 3)
					report_text($sformatf("header came %0d edges after rd_en low, not 3",
						lat_cnt));
				lat_arm  = 1'b0;
				in_frame = 1'b1;
				idx      = 0;
			end
		end
		if (in_frame)
		begin
			exp_v = bank_mem[cur][idx];
			if (data_out == '0 && exp_v != '0)
			begin
				aborts++;	// restarts from the header later.
				in_frame = 1'b0;
			end
			else
			begin
				if (data_out != exp_v)
					report_word($sformatf("word %0d", idx), exp_v, data_out);
				idx++;
				if (idx > DATA_WORDS)
				begin
					in_frame   = 1'b0;
					model_w[cur] = 1'b0;
					last       = cur;
					frames_done++;
				end
			end
		end
	endtask

	initial
	begin
		err_cnt     = 0;
		frames_done = 0;
		aborts      = 0;
		pending     = 0;
		in_frame    = 1'b0;
		model_w     = 2'b00;
		rdy_m       = 1'b0;
		lat_arm     = 1'b0;
		rd_prev     = 1'b1;
		cur         = BANK_0;
		last        = BANK_1;
		idx         = 0;
		lat_cnt     = 0;
		errs_base   = 0;
		forever
		begin
			@(posedge clk);
			if (g_rst)
			begin
				model_w  = 2'b00;
				rdy_m    = 1'b0;
				in_frame = 1'b0;
				last     = BANK_1;
				rd_prev  = 1'b1;
				lat_arm  = 1'b0;
			end
			else
			begin
				rdy_m = model_w[0] | model_w[1];	// flags before this edge.
				if (rd_prev && !rd_en)
				begin
					lat_cnt = 0;
					lat_arm = (model_w != 2'b00) && !in_frame;
				end
				else
					lat_cnt++;
				rd_prev = rd_en;
				if (acpt_sts)
				begin
					if (!model_w[0])
						store_frame(0);
					else if (!model_w[1])
						store_frame(1);
				end
			end
			if (test_end)
			begin
				$display("test %s finished, %0d errors", test_name(test_id),
					err_cnt + extra_errs - errs_base);
				errs_base = err_cnt + extra_errs;
			end
			@(negedge clk);
			if (g_rst)
			begin
				if (data_out != '0 || buff_rdy || wrtn0 || wrtn1)
					report_text("outputs not zero during reset");
			end
			else
			begin
				follow_stream();
				if (wrtn0 != model_w[0])
					report_word("rx_buff_0_wrtn", WORD_W'(model_w[0]), WORD_W'(wrtn0));
				if (wrtn1 != model_w[1])
					report_word("rx_buff_1_wrtn", WORD_W'(model_w[1]), WORD_W'(wrtn1));
				if (buff_rdy != rdy_m)
					report_word("buff_rdy", WORD_W'(rdy_m), WORD_W'(buff_rdy));
			end
			pending = int'(model_w[0]) + int'(model_w[1]);
		end
	end

endmodule

/* source/rx_buff.sv */
`timescale 1ns/1ns

module rx_buff
	import rx_frame_pkg::*;
#(
	parameter int WORD_W     = 64,
	parameter int DATA_WORDS = 8
) (
	input  logic                         clk,
	input  logic                         g_rst,
	input  logic                         acpt_sts,
	input  logic                         rd_en,
	input  logic [ID_W-1:0]              rcvd_prio_id,
	input  logic [DLC_W-1:0]             rcvd_dlc,
	input  logic                         rcvd_rrs,
	input  logic                         ide,
	input  logic                         fdf,
	input  logic                         xlf,
	input  logic                         resxl,
	input  logic [SDT_W-1:0]             sdt,
	input  logic [VCID_W-1:0]            vcid,
	input  logic                         sec,
	input  logic [WORD_W*DATA_WORDS-1:0] rcvd_data_frm,
	output logic [WORD_W-1:0]            data_out,
	output logic                         buff_rdy,
	output logic                         rx_buff_0_wrtn,
	output logic                         rx_buff_1_wrtn
);

	rx_hdr_t rcvd_hdr;

	assign rcvd_hdr = '{
		prio_id: rcvd_prio_id,
		rrs:     rcvd_rrs,
		ide:     ide,
		fdf:     fdf,
		xlf:     xlf,
		resxl:   resxl,
		sdt:     sdt,
		sec:     sec,
		dlc:     rcvd_dlc,
		vcid:    vcid
	};

	rx_bank_if #(.WORD_W(WORD_W), .DATA_WORDS(DATA_WORDS)) bank0_bus ();
	rx_bank_if #(.WORD_W(WORD_W), .DATA_WORDS(DATA_WORDS)) bank1_bus ();

	rx_buff_bank #(.WORD_W(WORD_W), .DATA_WORDS(DATA_WORDS)) u_bank0 (
		.clk   (clk),
		.g_rst (g_rst),
		.bus   (bank0_bus.bank)
	);

	rx_buff_bank #(.WORD_W(WORD_W), .DATA_WORDS(DATA_WORDS)) u_bank1 (
		.clk   (clk),
		.g_rst (g_rst),
		.bus   (bank1_bus.bank)
	);

	rx_buff_writer #(.WORD_W(WORD_W), .DATA_WORDS(DATA_WORDS)) u_writer (
		.acpt_sts      (acpt_sts),
		.rcvd_hdr      (rcvd_hdr),
		.rcvd_data_frm (rcvd_data_frm),
		.bank0         (bank0_bus.writer),
		.bank1         (bank1_bus.writer)
	);

	rx_buff_reader #(.WORD_W(WORD_W), .DATA_WORDS(DATA_WORDS)) u_reader (
		.clk      (clk),
		.g_rst    (g_rst),
		.rd_en    (rd_en),
		.bank0    (bank0_bus.reader),
		.bank1    (bank1_bus.reader),
		.data_out (data_out),
		.buff_rdy (buff_rdy)
	);

	assign rx_buff_0_wrtn = bank0_bus.written;
	assign rx_buff_1_wrtn = bank1_bus.written;

endmodule

/* source/rx_buff_reader.sv */
`timescale 1ns/1ns

module rx_buff_reader
	import rx_buff_pkg::*;
#(
	parameter int WORD_W     = 64,
	parameter int DATA_WORDS = 8
) (
	input  logic              clk,
	input  logic              g_rst,
	input  logic              rd_en,	// active low.
	rx_bank_if.reader         bank0,
	rx_bank_if.reader         bank1,
	output logic [WORD_W-1:0] data_out,
	output logic              buff_rdy
);

	localparam int IDX_W = $clog2(DATA_WORDS + 1);

	logic              rd_en_meta;
	logic              rd_en_sync;
	rd_state_t         state;
	bank_sel_t         active_bank;
	bank_sel_t         last_bank;
	logic [IDX_W-1:0]  word_idx;
	logic              last_word;
	logic              finish;
	logic [WORD_W-1:0] sel_word;

	// two flop sync, idles high.
	always_ff @(posedge clk or posedge g_rst)
	begin
		if (g_rst)
		begin
			rd_en_meta <= 1'b1;
			rd_en_sync <= 1'b1;
		end
		else
		begin
			rd_en_meta <= rd_en;
			rd_en_sync <= rd_en_meta;
		end
	end

	assign last_word = (word_idx == IDX_W'(DATA_WORDS));
	assign finish    = (state == RD_STREAM) && !rd_en_sync && last_word;
	assign sel_word  = (active_bank == BANK_1) ? bank1.rd_word : bank0.rd_word;

	assign bank0.rd_idx     = word_idx;
	assign bank1.rd_idx     = word_idx;
	assign bank0.rd_release = finish && (active_bank == BANK_0);
	assign bank1.rd_release = finish && (active_bank == BANK_1);

	always_ff @(posedge clk or posedge g_rst)
	begin
		if (g_rst)
		begin
			state       <= RD_IDLE;
			active_bank <= BANK_0;
			last_bank   <= BANK_1;	// so bank 0 goes first.
			word_idx    <= '0;
			data_out    <= '0;
		end
		else
		begin
			case (state)
				RD_IDLE:
				begin
					data_out <= '0;
					word_idx <= '0;
					if (!rd_en_sync && (bank0.written || bank1.written))
					begin
						state <= RD_STREAM;
						// both full, alternate.
						if (bank0.written && bank1.written)
							active_bank <= (last_bank == BANK_0) ? BANK_1 : BANK_0;
						else if (bank1.written)
							active_bank <= BANK_1;
						else
							active_bank <= BANK_0;
					end
				end
				RD_STREAM:
				begin
					if (rd_en_sync)
					begin
						state    <= RD_IDLE;	// abort, bank stays written.
						data_out <= '0;
					end
					else
					begin
						data_out <= sel_word;
						word_idx <= word_idx + IDX_W'(1);
						if (last_word)
						begin
							state     <= RD_IDLE;
							last_bank <= active_bank;
							word_idx  <= '0;
						end
					end
				end
				default:
					state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge g_rst)
	begin
		if (g_rst)
			buff_rdy <= 1'b0;
		else
			buff_rdy <= bank0.written || bank1.written;
	end

endmodule

/* source/rx_buff_writer.sv */
`timescale 1ns/1ns

module rx_buff_writer
	import rx_frame_pkg::*;
#(
	parameter int WORD_W     = 64,
	parameter int DATA_WORDS = 8
) (
	input  logic                         acpt_sts,
	input  rx_hdr_t                      rcvd_hdr,
	input  logic [WORD_W*DATA_WORDS-1:0] rcvd_data_frm,
	rx_bank_if.writer                    bank0,
	rx_bank_if.writer                    bank1
);

	rx_hdr_t           hdr_adj;
	logic [WORD_W-1:0] hdr_word;
	logic              sel0;
	logic              sel1;

	// secured frames carry 16 extra bytes in the dlc.
	always_comb
	begin
		hdr_adj = rcvd_hdr;
		if (rcvd_hdr.sec)
			hdr_adj.dlc = rcvd_hdr.dlc - SEC_DLC_ADJUST;
	end

	// header sits at the top of the word.
	always_comb
	begin
		hdr_word = '0;
		hdr_word[WORD_W-1 -: HDR_W] = hdr_adj;
	end

	// first free bank takes the frame, none free drops it.
	assign sel0 = !bank0.written;
	assign sel1 = bank0.written && !bank1.written;

	assign bank0.wr = acpt_sts && sel0;
	assign bank1.wr = acpt_sts && sel1;

	assign bank0.wr_hdr_word = hdr_word;
	assign bank1.wr_hdr_word = hdr_word;
	assign bank0.wr_frame    = rcvd_data_frm;
	assign bank1.wr_frame    = rcvd_data_frm;

endmodule

/* source/rx_buff_bank.sv */
`timescale 1ns/1ns

module rx_buff_bank #(
	parameter int WORD_W     = 64,
	parameter int DATA_WORDS = 8
) (
	input logic     clk,
	input logic     g_rst,
	rx_bank_if.bank bus
);

	// word 0 is the header, then the frame slices from the top down.
	logic [WORD_W-1:0] mem [0:DATA_WORDS];
	logic              written_q;

	always_ff @(posedge clk or posedge g_rst)
	begin
		if (g_rst)
			written_q <= 1'b0;
		else if (bus.rd_release)
			written_q <= 1'b0;	// release wins over a load.
		else if (bus.wr)
			written_q <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (bus.wr && !bus.rd_release)
		begin
			mem[0] <= bus.wr_hdr_word;
			for (int i = 1; i <= DATA_WORDS; i++)
				mem[i] <= bus.wr_frame[(DATA_WORDS - i) * WORD_W +: WORD_W];
		end
	end

	assign bus.written = written_q;
	assign bus.rd_word = mem[bus.rd_idx];	// async read.

endmodule

/* source/rx_bank_if.sv */
`timescale 1ns/1ns

interface rx_bank_if #(
	parameter int WORD_W     = 64,
	parameter int DATA_WORDS = 8
);
	localparam int IDX_W = $clog2(DATA_WORDS + 1);

	logic                         wr;	// load strobe from the writer.
	logic [WORD_W-1:0]            wr_hdr_word;
	logic [WORD_W*DATA_WORDS-1:0] wr_frame;
	logic                         written;
	logic                         rd_release;	// one cycle, end of readout.
	logic [IDX_W-1:0]             rd_idx;
	logic [WORD_W-1:0]            rd_word;

	modport writer (
		output wr, wr_hdr_word, wr_frame,
		input  written
	);

	modport reader (
		output rd_release, rd_idx,
		input  written, rd_word
	);

	modport bank (
		input  wr, wr_hdr_word, wr_frame, rd_release, rd_idx,
		output written, rd_word
	);

endinterface

/* source/rx_buff_pkg.sv */
package rx_buff_pkg;

	// read sequencer states.
	typedef enum logic {
		RD_IDLE,
		RD_STREAM
	} rd_state_t;

	// message bank select.
	typedef enum logic {
		BANK_0,
		BANK_1
	} bank_sel_t;

endpackage

/* source/rx_frame_pkg.sv */
package rx_frame_pkg;

	parameter int ID_W   = 11;	// priority identifier.
	parameter int DLC_W  = 11;
	parameter int SDT_W  = 8;	// sdu type.
	parameter int VCID_W = 8;	// virtual can id.

	// prio_id, five single flags, sdt, sec, dlc, vcid.
	parameter int HDR_W = ID_W + 5 + SDT_W + 1 + DLC_W + VCID_W;

	// taken off the dlc when the security bit is set.
	parameter logic [DLC_W-1:0] SEC_DLC_ADJUST = DLC_W'(16);

	typedef struct packed {
		logic [ID_W-1:0]   prio_id;
		logic              rrs;
		logic              ide;
		logic              fdf;
		logic              xlf;
		logic              resxl;
		logic [SDT_W-1:0]  sdt;
		logic              sec;
		logic [DLC_W-1:0]  dlc;
		logic [VCID_W-1:0] vcid;
	} rx_hdr_t;

endpackage
